// File: flist.f
verilog/ahbPkg.sv
verilog/lsuPkg.sv
verilog/busFsm.sv
verilog/waitTimer.sv
verilog/addrPhase.sv
verilog/readAlign.sv
verilog/amoAlu.sv
verilog/ahbMaster.sv
bench/ahbSlaveModel.sv
bench/ahbMasterTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ahbMasterTb
OBJDIR    ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing -j 0
PASSMSG   ?= ALL TESTS PASSED

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee /dev/stderr | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: bench/ahbMasterTb.sv
`default_nettype none

module ahbMasterTb;
  timeunit 1ns;
  timeprecision 100ps;
  import ahbPkg::*;
  import lsuPkg::*;

  localparam int TimeoutCycles = 16;
  localparam int NumData       = 200;
  localparam int NumInstr      = 150;
  localparam int NumHang       = 4;
  // Every request gets the worst case of a hang plus some slack
  // One more for the fetch held across reset
  localparam int CycleLimit    = (NumData + NumInstr + 2 * NumHang + 1) * (TimeoutCycles + 10);

  // Expected response with its grant cycle
  typedef struct packed {
    rspT         rsp;
    logic        hang;
    logic [31:0] cyc;
  } expT;

  logic        HCLK;
  logic        HRESETn;
  logic        instrValid;
  logic        instrReady;
  instrReqT    instrReq;
  logic        instrRspValid;
  rspT         instrRsp;
  logic        dataValid;
  logic        dataReady;
  dataReqT     dataReq;
  logic        dataRspValid;
  rspT         dataRsp;
  logic [31:0] HADDR;
  logic        HWRITE;
  hsizeT       HSIZE;
  htransT      HTRANS;
  logic        HMASTLOCK;
  logic [31:0] HWDATA;
  logic [31:0] HRDATA;
  logic        HREADY;
  logic        HRESP;
  logic        abortHang;

  logic [31:0] seed;
  logic [31:0] model [256];
  expT         dataQ[$];
  expT         instrQ[$];
  logic        dataTaken;
  logic        instrTaken;
  int          amoDue;
  logic [31:0] amoAddrHeld;
  logic [31:0] cycle;

  ahbMaster #(
    .TimeoutCycles (TimeoutCycles)
  ) u_dut (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .instrValid    (instrValid),
    .instrReady    (instrReady),
    .instrReq      (instrReq),
    .instrRspValid (instrRspValid),
    .instrRsp      (instrRsp),
    .dataValid     (dataValid),
    .dataReady     (dataReady),
    .dataReq       (dataReq),
    .dataRspValid  (dataRspValid),
    .dataRsp       (dataRsp),
    .HADDR         (HADDR),
    .HWRITE        (HWRITE),
    .HSIZE         (HSIZE),
    .HTRANS        (HTRANS),
    .HMASTLOCK     (HMASTLOCK),
    .HWDATA        (HWDATA),
    .HRDATA        (HRDATA),
    .HREADY        (HREADY),
    .HRESP         (HRESP)
  );

  ahbSlaveModel u_slave (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HWDATA    (HWDATA),
    .HRDATA    (HRDATA),
    .HREADY    (HREADY),
    .HRESP     (HRESP),
    .abortHang (abortHang)
  );

  always #10 HCLK = ~HCLK;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Start pattern, every bit of the word index matters
  function automatic logic [31:0] fillWord(input logic [7:0] i);
    return {i, ~i, i ^ 8'h5a, i + 8'h33} ^ 32'h9e3779b9;
  endfunction

  function automatic logic [31:0] loadVal(input logic [31:0] w, input logic [1:0] low,
                                          input hsizeT size, input logic uns);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[{low, 3'b000} +: 8];
    h = low[1] ? w[31:16] : w[15:0];
    case (size)
      BYTE:    return uns ? {24'h0, b} : {{24{b[7]}}, b};
      HALF:    return uns ? {16'h0, h} : {{16{h[15]}}, h};
      default: return w;
    endcase
  endfunction

  function automatic logic [31:0] storeMerge(input logic [31:0] w, input logic [1:0] low,
                                             input hsizeT size, input logic [31:0] d);
    logic [31:0] r;
    r = w;
    case (size)
      BYTE:    r[{low, 3'b000} +: 8] = d[7:0];
      HALF:    r[{low[1], 4'b0000} +: 16] = d[15:0];
      default: r = d;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] amoCalc(input memOpT op, input logic [31:0] old,
                                          input logic [31:0] opnd);
    case (op)
      AMOADD:  return old + opnd;
      AMOAND:  return old & opnd;
      AMOOR:   return old | opnd;
      AMOXOR:  return old ^ opnd;
      default: return opnd;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic checkRsp(input string name, input rspT got, input rspT exp);
    if (got !== exp) begin
      stopRun($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkAddr(input ahbAddrT got, input ahbAddrT exp);
    if (got !== exp) begin
      stopRun($sformatf("** Error: address phase got %h expected %h", got, exp));
    end
  endtask

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stopRun($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge HCLK) begin
    ahbAddrT pins;
    ahbAddrT expA;
    expT     e;
    logic    bad;
    logic    isAmo;
    cycle = cycle + 1;
    if (cycle > CycleLimit) begin
      stopRun("Timeout: the run did not finish within the cycle limit");
    end
    if (HRESETn) begin
      pins = '{haddr: HADDR, hwrite: HWRITE, hsize: HSIZE, htrans: HTRANS, hmastlock: HMASTLOCK};
      if (instrReady && dataReady) begin
        stopRun("Both ports were offered the bus in the same cycle");
      end
      if (dataValid && instrReady) begin
        stopRun("Fetch port was ready while a data request waited");
      end
      // Responses in grant order per port
      if (dataRspValid) begin
        if (dataQ.size() == 0) begin
          stopRun("Data response came with no request outstanding");
        end
        e = dataQ.pop_front();
        checkRsp("dataRsp", dataRsp, e.rsp);
        if (e.hang && (cycle != e.cyc + TimeoutCycles + 1)) begin
          stopRun("Data hang response came at the wrong cycle");
        end
      end
      if (instrRspValid) begin
        if (instrQ.size() == 0) begin
          stopRun("Fetch response came with no request outstanding");
        end
        e = instrQ.pop_front();
        checkRsp("instrRsp", instrRsp, e.rsp);
        if (e.hang && (cycle != e.cyc + TimeoutCycles + 1)) begin
          stopRun("Fetch hang response came at the wrong cycle");
        end
      end
      // Grants update the model in bus order
      if (dataValid && dataReady) begin
        isAmo = (dataReq.op != LOAD) && (dataReq.op != STORE);
        expA  = '{haddr: dataReq.addr, hwrite: (dataReq.op == STORE), hsize: dataReq.size,
                  htrans: NONSEQ, hmastlock: isAmo};
        checkAddr(pins, expA);
        bad   = dataReq.addr[31] || dataReq.addr[30];
        e.hang = dataReq.addr[30];
        e.cyc  = cycle;
        e.rsp  = '{rdata: 32'h0, err: 1'b1};
        if (!bad) begin
          e.rsp.err = 1'b0;
          case (dataReq.op)
            LOAD: begin
              e.rsp.rdata = loadVal(model[dataReq.addr[9:2]], dataReq.addr[1:0],
                                    dataReq.size, dataReq.isUnsigned);
            end
            STORE: begin
              model[dataReq.addr[9:2]] = storeMerge(model[dataReq.addr[9:2]],
                                         dataReq.addr[1:0], dataReq.size, dataReq.wdata);
            end
            default: begin
              e.rsp.rdata = model[dataReq.addr[9:2]];
              model[dataReq.addr[9:2]] = amoCalc(dataReq.op, e.rsp.rdata, dataReq.wdata);
              amoDue      = amoDue + 1;
              amoAddrHeld = dataReq.addr;
            end
          endcase
        end
        dataQ.push_back(e);
        dataTaken = 1'b1;
      end else if (instrValid && instrReady) begin
        expA = '{haddr: instrReq.addr, hwrite: 1'b0, hsize: WORD, htrans: NONSEQ,
                 hmastlock: 1'b0};
        checkAddr(pins, expA);
        e.hang = instrReq.addr[30];
        e.cyc  = cycle;
        e.rsp  = '{rdata: 32'h0, err: 1'b1};
        if (!instrReq.addr[31] && !instrReq.addr[30]) begin
          e.rsp = '{rdata: model[instrReq.addr[9:2]], err: 1'b0};
        end
        instrQ.push_back(e);
        instrTaken = 1'b1;
      end else if (HTRANS == NONSEQ) begin
        // Only the locked write of an atomic goes out without a grant
        if (amoDue == 0) begin
          stopRun("Address phase appeared with no grant and no atomic pending");
        end
        expA = '{haddr: amoAddrHeld, hwrite: 1'b1, hsize: WORD, htrans: NONSEQ,
                 hmastlock: 1'b1};
        checkAddr(pins, expA);
        amoDue = amoDue - 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic makeDataReq();
    logic [31:0] r;
    logic [31:0] a;
    r = $random(seed);
    if (r[3:0] < 4'd6) begin
      dataReq.op = LOAD;
    end else if (r[3:0] < 4'd11) begin
      dataReq.op = STORE;
    end else begin
      dataReq.op = memOpT'(3'(2 + r[6:4] % 3'd5));
    end
    // Atomics stay whole words
    if ((dataReq.op == LOAD) || (dataReq.op == STORE)) begin
      dataReq.size = hsizeT'(3'(r[8:7] % 2'd3));
    end else begin
      dataReq.size = WORD;
    end
    a = {(r[22:19] == 4'd0), 1'b0, 20'h0, r[18:9]};
    if (dataReq.size == HALF) begin
      a[0] = 1'b0;
    end else if (dataReq.size == WORD) begin
      a[1:0] = 2'b00;
    end
    dataReq.addr       = a;
    dataReq.isUnsigned = r[23];
    dataReq.wdata      = $random(seed);
  endtask

  task automatic makeInstrReq();
    logic [31:0] r;
    r = $random(seed);
    instrReq.addr = {(r[15:12] == 4'd0), 1'b0, 20'h0, r[9:2], 2'b00};
  endtask

  task automatic waitGrant();
    do begin
      @(negedge HCLK);
    end while (!dataTaken && !instrTaken);
    dataValid  = 1'b0;
    instrValid = 1'b0;
    dataTaken  = 1'b0;
    instrTaken = 1'b0;
  endtask

  task automatic waitDrained();
    while ((dataQ.size() != 0) || (instrQ.size() != 0) || (amoDue != 0)) begin
      @(negedge HCLK);
    end
  endtask

  // Both ports busy at once, random pauses between requests
  task automatic runRandom();
    int          dataLeft;
    int          instrLeft;
    logic [31:0] r;
    dataLeft  = NumData;
    instrLeft = NumInstr;
    while ((dataLeft > 0) || (instrLeft > 0) || dataValid || instrValid) begin
      @(negedge HCLK);
      r = $random(seed);
      if (dataTaken || !dataValid) begin
        dataTaken = 1'b0;
        dataValid = (dataLeft > 0) && (r[1:0] != 2'b00);
        if (dataValid) begin
          makeDataReq();
          dataLeft = dataLeft - 1;
        end
      end
      if (instrTaken || !instrValid) begin
        instrTaken = 1'b0;
        instrValid = (instrLeft > 0) && (r[3:2] != 2'b00);
        if (instrValid) begin
          makeInstrReq();
          instrLeft = instrLeft - 1;
        end
      end
    end
    waitDrained();
  endtask

  // One stuck transfer at a time, then a normal load
  task automatic runHang();
    logic [31:0] r;
    for (int k = 0; k < NumHang; k++) begin
      @(negedge HCLK);
      if (k % 2 == 1) begin
        r = $random(seed);
        instrReq.addr = {2'b01, 20'h0, r[9:2], 2'b00};
        instrValid    = 1'b1;
      end else begin
        makeDataReq();
        dataReq.op       = (k % 4 == 2) ? STORE : LOAD;
        dataReq.addr[31] = 1'b0;
        dataReq.addr[30] = 1'b1;
        dataValid        = 1'b1;
      end
      waitGrant();
      waitDrained();
      abortHang = 1'b1;
      @(negedge HCLK);
      abortHang = 1'b0;
      @(negedge HCLK);
      makeDataReq();
      dataReq.op       = LOAD;
      dataReq.addr[31] = 1'b0;
      dataValid        = 1'b1;
      waitGrant();
      waitDrained();
    end
  endtask

  initial begin
    HCLK       = 1'b0;
    HRESETn    = 1'b0;
    // Fetch already asking while reset is held
    instrValid = 1'b1;
    instrReq   = '0;
    dataValid  = 1'b0;
    dataReq    = '0;
    abortHang  = 1'b0;
    seed       = 32'hff88;
    dataTaken  = 1'b0;
    instrTaken = 1'b0;
    amoDue     = 0;
    amoAddrHeld = 32'h0;
    cycle      = 32'h0;
    for (int i = 0; i < 256; i++) begin
      model[i]       = fillWord(8'(i));
      u_slave.mem[i] = fillWord(8'(i));
    end
    repeat (5) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    #1;
    // Quiet until the first edge after release
    if (instrReady || dataReady || instrRspValid || dataRspValid) begin
      stopRun("Port handshakes were active before the first clock after reset");
    end
    if ((HTRANS != ahbPkg::IDLE) || HMASTLOCK) begin
      stopRun("Bus was not idle before the first clock after reset");
    end
    @(negedge HCLK);
    if (!instrReady) begin
      stopRun("Fetch ready did not rise in the first cycle after reset");
    end
    runRandom();
    runHang();
    for (int i = 0; i < 256; i++) begin
      checkWord($sformatf("mem[%0d]", i), u_slave.mem[i], model[i]);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/ahbSlaveModel.sv
`default_nettype none

module ahbSlaveModel #(
  parameter logic [31:0] Seed = 32'hff88
) (
  input  wire logic           HCLK,
  input  wire logic           HRESETn,
  input  wire logic [31:0]    HADDR,
  input  wire logic           HWRITE,
  input  wire ahbPkg::hsizeT  HSIZE,
  input  wire ahbPkg::htransT HTRANS,
  input  wire logic [31:0]    HWDATA,
  output logic [31:0]         HRDATA,
  output logic                HREADY,
  output logic                HRESP,
  input  wire logic           abortHang
);
  timeunit 1ns;
  timeprecision 100ps;
  import ahbPkg::*;

  // Word memory, indexed by HADDR[9:2]
  logic [31:0] mem [256];

  logic [31:0] seed;
  logic [31:0] rnd;
  logic        pending;
  logic [31:0] pAddr;
  logic        pWrite;
  hsizeT       pSize;
  logic [1:0]  waitCnt;
  logic        pErr;
  logic        pHang;

  initial seed = Seed;

  // Hang region never finishes on its own
  assign HREADY = !pending || ((waitCnt == 2'd0) && !pHang);
  assign HRESP  = pending && pErr && HREADY;
  assign HRDATA = (pending && !pWrite) ? mem[pAddr[9:2]] : 32'h0;

  always @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      pending <= 1'b0;
      pAddr   <= 32'h0;
      pWrite  <= 1'b0;
      pSize   <= WORD;
      waitCnt <= 2'd0;
      pErr    <= 1'b0;
      pHang   <= 1'b0;
    end else if (HREADY) begin
      // Finished write lands in the lanes it covers
      if (pending && pWrite && !pErr) begin
        case (pSize)
          BYTE:    mem[pAddr[9:2]][{pAddr[1:0], 3'b000} +: 8] <= HWDATA[{pAddr[1:0], 3'b000} +: 8];
          HALF:    mem[pAddr[9:2]][{pAddr[1], 4'b0000} +: 16] <= HWDATA[{pAddr[1], 4'b0000} +: 16];
          default: mem[pAddr[9:2]] <= HWDATA;
        endcase
      end
      // Address phase is taken only with HREADY high
      pending <= (HTRANS == NONSEQ);
      if (HTRANS == NONSEQ) begin
        rnd     = $random(seed);
        pAddr   <= HADDR;
        pWrite  <= HWRITE;
        pSize   <= HSIZE;
        waitCnt <= rnd[1:0];
        pErr    <= HADDR[31];
        pHang   <= HADDR[30];
      end
    end else if (abortHang) begin
      // Bench drops a stuck transfer once the master gave up
      pending <= 1'b0;
      pHang   <= 1'b0;
    end else if (waitCnt != 2'd0) begin
      waitCnt <= waitCnt - 2'd1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ahbMaster.sv
`default_nettype none

module ahbMaster #(
  parameter int TimeoutCycles = 16
) (
  input  logic             HCLK,
  input  logic             HRESETn,
  // Fetch port
  input  logic             instrValid,
  output logic             instrReady,
  input  lsuPkg::instrReqT instrReq,
  output logic             instrRspValid,
  output lsuPkg::rspT      instrRsp,
  // Data port
  input  logic             dataValid,
  output logic             dataReady,
  input  lsuPkg::dataReqT  dataReq,
  output logic             dataRspValid,
  output lsuPkg::rspT      dataRsp,
  // AHB-Lite pins
  output logic [31:0]      HADDR,
  output logic             HWRITE,
  output ahbPkg::hsizeT    HSIZE,
  output ahbPkg::htransT   HTRANS,
  output logic             HMASTLOCK,
  output logic [31:0]      HWDATA,
  input  logic [31:0]      HRDATA,
  input  logic             HREADY,
  input  logic             HRESP
);
  import ahbPkg::*;
  import lsuPkg::*;

  logic        grantData;
  logic        grantInstr;
  logic        atomicWrite;
  logic        inDataPhase;
  logic        expired;
  logic        rspErr;
  logic [31:0] amoResult;
  logic [31:0] oldValue;
  logic [31:0] rdata;
  memOpT       amoOp;
  phaseT       phase;
  ahbAddrT     addrOut;

  busFsm u_busFsm (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .instrValid    (instrValid),
    .dataValid     (dataValid),
    .dataOp        (dataReq.op),
    .HREADY        (HREADY),
    .HRESP         (HRESP),
    .expired       (expired),
    .instrReady    (instrReady),
    .dataReady     (dataReady),
    .grantData     (grantData),
    .grantInstr    (grantInstr),
    .atomicWrite   (atomicWrite),
    .inDataPhase   (inDataPhase),
    .instrRspValid (instrRspValid),
    .dataRspValid  (dataRspValid),
    .rspErr        (rspErr),
    .state         ()
  );

  waitTimer #(
    .TimeoutCycles (TimeoutCycles)
  ) u_waitTimer (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .inDataPhase (inDataPhase),
    .HREADY      (HREADY),
    .expired     (expired)
  );

  addrPhase u_addrPhase (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .grantData   (grantData),
    .grantInstr  (grantInstr),
    .atomicWrite (atomicWrite),
    .dataReq     (dataReq),
    .instrReq    (instrReq),
    .amoResult   (amoResult),
    .HRDATA      (HRDATA),
    .addrOut     (addrOut),
    .HWDATA      (HWDATA),
    .phase       (phase),
    .amoOp       (amoOp),
    .oldValue    (oldValue)
  );

  readAlign u_readAlign (
    .HRDATA   (HRDATA),
    .phase    (phase),
    .oldValue (oldValue),
    .err      (rspErr),
    .rdata    (rdata)
  );

  // Operand is the held write data of the atomic read phase
  amoAlu u_amoAlu (
    .oldValue (HRDATA),
    .operand  (HWDATA),
    .op       (amoOp),
    .result   (amoResult)
  );

  // Address phase bundle onto the pins
  assign HADDR     = addrOut.haddr;
  assign HWRITE    = addrOut.hwrite;
  assign HSIZE     = addrOut.hsize;
  assign HTRANS    = addrOut.htrans;
  assign HMASTLOCK = addrOut.hmastlock;

  // Both ports share the aligned data and error flag
  assign instrRsp.rdata = rdata;
  assign instrRsp.err   = rspErr;
  assign dataRsp.rdata  = rdata;
  assign dataRsp.err    = rspErr;

endmodule

`default_nettype wire

// File: verilog/amoAlu.sv
`default_nettype none

module amoAlu (
  input  logic [31:0]   oldValue,
  input  logic [31:0]   operand,
  input  lsuPkg::memOpT op,
  output logic [31:0]   result
);
  import lsuPkg::*;

  //////////////////////////////////////////////////////////////////////
  // Read-modify-write arithmetic
  //////////////////////////////////////////////////////////////////////

  // Old value comes straight off HRDATA at the end of the locked read
  always_comb begin
    case (op)
      AMOADD:  result = oldValue + operand;
      AMOAND:  result = oldValue & operand;
      AMOOR:   result = oldValue | operand;
      AMOXOR:  result = oldValue ^ operand;
      // Swap stores the operand as is
      default: result = operand;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/readAlign.sv
`default_nettype none

module readAlign (
  input  logic [31:0]   HRDATA,
  input  lsuPkg::phaseT phase,
  input  logic [31:0]   oldValue,
  input  logic          err,
  output logic [31:0]   rdata
);
  import ahbPkg::*;

  logic [7:0]  byteLane;
  logic [15:0] halfLane;
  logic        extBit;

  // Lane picked by the low address bits
  assign byteLane = HRDATA[{phase.addrLow, 3'b000} +: 8];
  assign halfLane = phase.addrLow[1] ? HRDATA[31:16] : HRDATA[15:0];

  // Sign bit of the picked lane, zero for unsigned loads
  assign extBit = !phase.isUnsigned && ((phase.size == BYTE) ? byteLane[7] : halfLane[15]);

  always_comb begin
    rdata = HRDATA;
    if (err) begin
      // Error responses return zero data
      rdata = '0;
    end else if (phase.isData && phase.isWrite) begin
      // Writes answer with the held old value, zero for plain stores
      rdata = oldValue;
    end else if (phase.isData) begin
      case (phase.size)
        BYTE:    rdata = {{24{extBit}}, byteLane};
        HALF:    rdata = {{16{extBit}}, halfLane};
        default: rdata = HRDATA;
      endcase
    end
  end

  // Requester must keep halfwords aligned
  always_comb begin
    if (phase.size == HALF) begin
      halfAligned: assert (!phase.addrLow[0]);
    end
  end

endmodule

`default_nettype wire

// File: verilog/addrPhase.sv
`default_nettype none

module addrPhase (
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic             grantData,
  input  logic             grantInstr,
  input  logic             atomicWrite,
  input  lsuPkg::dataReqT  dataReq,
  input  lsuPkg::instrReqT instrReq,
  input  logic [31:0]      amoResult,
  input  logic [31:0]      HRDATA,
  output ahbPkg::ahbAddrT  addrOut,
  output logic [31:0]      HWDATA,
  output lsuPkg::phaseT    phase,
  output lsuPkg::memOpT    amoOp,
  output logic [31:0]      oldValue
);
  import ahbPkg::*;
  import lsuPkg::*;

  logic [31:0] amoAddr;
  hsizeT       amoSize;
  logic        isAmo;

  // Copy a narrow store into every lane it may land in
  function automatic logic [31:0] laneFill(input logic [31:0] d, input hsizeT size);
    case (size)
      BYTE:    return {4{d[7:0]}};
      HALF:    return {2{d[15:0]}};
      default: return d;
    endcase
  endfunction

  assign isAmo = (dataReq.op != LOAD) && (dataReq.op != STORE);

  //////////////////////////////////////////////////////////////////////
  // Address phase mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    addrOut.haddr     = instrReq.addr;
    addrOut.hwrite    = 1'b0;
    addrOut.hsize     = WORD;
    addrOut.htrans    = ahbPkg::IDLE;
    addrOut.hmastlock = 1'b0;
    if (atomicWrite) begin
      // Second half of an atomic, same address as the read
      addrOut.haddr     = amoAddr;
      addrOut.hwrite    = 1'b1;
      addrOut.hsize     = amoSize;
      addrOut.htrans    = NONSEQ;
      addrOut.hmastlock = 1'b1;
    end else if (grantData) begin
      addrOut.haddr     = dataReq.addr;
      addrOut.hwrite    = (dataReq.op == STORE);
      addrOut.hsize     = dataReq.size;
      addrOut.htrans    = NONSEQ;
      addrOut.hmastlock = isAmo;
    end else if (grantInstr) begin
      addrOut.htrans = NONSEQ;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data phase registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      phase <= '0;
    end else if (atomicWrite) begin
      phase <= '{isData: 1'b1, isWrite: 1'b1, size: amoSize,
                 isUnsigned: 1'b0, addrLow: amoAddr[1:0]};
    end else if (grantData) begin
      phase <= '{isData: 1'b1, isWrite: (dataReq.op == STORE), size: dataReq.size,
                 isUnsigned: dataReq.isUnsigned, addrLow: dataReq.addr[1:0]};
    end else if (grantInstr) begin
      phase <= '{isData: 1'b0, isWrite: 1'b0, size: WORD,
                 isUnsigned: 1'b0, addrLow: instrReq.addr[1:0]};
    end
  end

  always_ff @(posedge HCLK) begin
    if (atomicWrite) begin
      HWDATA   <= laneFill(amoResult, amoSize);
      // Old memory word, returned when the write completes
      oldValue <= HRDATA;
    end else if (grantData) begin
      // Atomic operand rides here through the read phase
      HWDATA   <= laneFill(dataReq.wdata, dataReq.size);
      oldValue <= '0;
      if (isAmo) begin
        amoAddr <= dataReq.addr;
        amoSize <= dataReq.size;
        amoOp   <= dataReq.op;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/waitTimer.sv
`default_nettype none

module waitTimer #(
  parameter int TimeoutCycles = 16
) (
  input  logic HCLK,
  input  logic HRESETn,
  input  logic inDataPhase,
  input  logic HREADY,
  output logic expired
);

  localparam int CountW = $clog2(TimeoutCycles + 1);
  localparam logic [CountW-1:0] LastCount = CountW'(TimeoutCycles - 1);

  logic [CountW-1:0] count;
  logic              waiting;

  // A wait state is a data phase cycle with HREADY low
  assign waiting = inDataPhase && !HREADY;

  // Fires on the last allowed wait state
  assign expired = waiting && (count == LastCount);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      count <= '0;
    end else if (!waiting || expired) begin
      // Restart on any completed or abandoned data phase
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // Count wraps back before it can pass the limit
  countBound: assert property (@(posedge HCLK) disable iff (!HRESETn)
    count <= LastCount);

endmodule

`default_nettype wire

// File: verilog/busFsm.sv
`default_nettype none

module busFsm (
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic             instrValid,
  input  logic             dataValid,
  input  lsuPkg::memOpT    dataOp,
  input  logic             HREADY,
  input  logic             HRESP,
  input  logic             expired,
  output logic             instrReady,
  output logic             dataReady,
  output logic             grantData,
  output logic             grantInstr,
  output logic             atomicWrite,
  output logic             inDataPhase,
  output logic             instrRspValid,
  output logic             dataRspValid,
  output logic             rspErr,
  output lsuPkg::busStateT state
);
  import lsuPkg::*;

  busStateT nextState;
  logic     busUp;
  logic     busFree;
  logic     phaseEnd;
  logic     dataEnd;
  logic     stickyErr;
  logic     toPend;
  logic     toData;

  //////////////////////////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////////////////////////

  assign inDataPhase = (state != IDLE);
  assign phaseEnd    = inDataPhase && HREADY;

  // Free for a new address phase when idle or the current data phase ends,
  // except after an atomic read which owns the next address phase
  assign busFree = busUp && ((state == IDLE) || (phaseEnd && (state != ATOMICREAD)));

  // Data side wins, fetch waits whenever data asks
  assign dataReady  = busFree && dataValid;
  assign instrReady = busFree && !dataValid;
  assign grantData  = dataValid && dataReady;
  assign grantInstr = instrValid && instrReady;

  // Locked write follows a clean atomic read straight away
  assign atomicWrite = phaseEnd && (state == ATOMICREAD) && !HRESP;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    nextState = IDLE;
    if (inDataPhase && !HREADY) begin
      // Stretch the data phase until the watchdog gives up
      nextState = expired ? IDLE : state;
    end else if (atomicWrite) begin
      nextState = ATOMICWRITE;
    end else if (grantData) begin
      case (dataOp)
        LOAD:    nextState = MEMREAD;
        STORE:   nextState = MEMWRITE;
        default: nextState = ATOMICREAD;
      endcase
    end else if (grantInstr) begin
      nextState = INSTRREAD;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= IDLE;
      busUp     <= 1'b0;
      stickyErr <= 1'b0;
      toPend    <= 1'b0;
      toData    <= 1'b0;
    end else begin
      state  <= nextState;
      busUp  <= 1'b1;
      // Timeout answer goes out the cycle after expiry
      toPend <= expired;
      toData <= (state != INSTRREAD);
      // Error seen by the read half of an atomic
      if (phaseEnd && (state == ATOMICREAD)) begin
        stickyErr <= HRESP;
      end else if (state != ATOMICWRITE) begin
        stickyErr <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Responses
  //////////////////////////////////////////////////////////////////////

  // Any data phase end answers, apart from the read half of a good atomic
  assign dataEnd = phaseEnd && (state != INSTRREAD) && !atomicWrite;

  assign instrRspValid = (phaseEnd && (state == INSTRREAD)) || (toPend && !toData);
  assign dataRspValid  = dataEnd || (toPend && toData);

  // Shared error flag, only one response per cycle
  assign rspErr = toPend || (phaseEnd && (HRESP || (stickyErr && (state == ATOMICWRITE))));

  // Both ports never offered the bus at once
  readyExclusive: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(instrReady && dataReady));

  // Watchdog only fires while a transfer is in its data phase
  expiredInPhase: assert property (@(posedge HCLK) disable iff (!HRESETn)
    expired |-> inDataPhase);

endmodule

`default_nettype wire

// File: verilog/lsuPkg.sv
`default_nettype none

package lsuPkg;

  //////////////////////////////////////////////////////////////////////
  // Core-side operations and bus states
  //////////////////////////////////////////////////////////////////////

  // Data port operations
  typedef enum logic [2:0] {
    LOAD,
    STORE,
    AMOSWAP,
    AMOADD,
    AMOAND,
    AMOOR,
    AMOXOR
  } memOpT;

  // Kind of transfer now in its data phase
  typedef enum logic [2:0] {
    IDLE,
    INSTRREAD,
    MEMREAD,
    MEMWRITE,
    ATOMICREAD,
    ATOMICWRITE
  } busStateT;

  //////////////////////////////////////////////////////////////////////
  // Request and response bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    memOpT         op;
    logic [31:0]   addr;
    ahbPkg::hsizeT size;
    // Zero extension on loads
    logic          isUnsigned;
    // Store data, or operand of an atomic
    logic [31:0]   wdata;
  } dataReqT;

  // Fetches are always whole words
  typedef struct packed {
    logic [31:0] addr;
  } instrReqT;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } rspT;

  // What the data phase in flight belongs to
  typedef struct packed {
    logic          isData;
    logic          isWrite;
    ahbPkg::hsizeT size;
    logic          isUnsigned;
    logic [1:0]    addrLow;
  } phaseT;

endpackage

`default_nettype wire

// File: verilog/ahbPkg.sv
`default_nettype none

package ahbPkg;

  //////////////////////////////////////////////////////////////////////
  // AHB-Lite bus encodings
  //////////////////////////////////////////////////////////////////////

  // HTRANS, single transfers only so no BUSY or SEQ
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10
  } htransT;

  // HSIZE, bus is 32 bits so word is the widest
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsizeT;

  //////////////////////////////////////////////////////////////////////
  // Address phase bundle
  //////////////////////////////////////////////////////////////////////

  // Everything the master drives during an address phase
  typedef struct packed {
    logic [31:0] haddr;
    logic        hwrite;
    hsizeT       hsize;
    htransT      htrans;
    // High on both halves of an atomic
    logic        hmastlock;
  } ahbAddrT;

endpackage

`default_nettype wire
